/* filelist.f */
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/core_ctrl.sv
verilog/bus_wait_timer.sv
verilog/decoder.sv
verilog/register_file.sv
verilog/exec_unit.sv
verilog/cpu_top.sv
testbench/tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cpu testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_cpu -f filelist.f -o sim_tb_cpu
./obj_dir/sim_tb_cpu > sim.log 2>&1 || true
cat sim.log

if grep -qx "Everything OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* testbench/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
	localparam int N_INST  = 60;
	localparam int CLK_NS  = 100;
	localparam int MAX_LAT = 4;
	// three programs, each bounded by the slowest instruction plus slack
	localparam int WATCHDOG_NS = 3 * (N_INST * (2 * MAX_LAT + 4) + 200) * CLK_NS;
	localparam logic [31:0] RESET_PC     = 32'h0000_0000;
	localparam logic [31:0] ILLEGAL_WORD = 32'hFFFF_FFFF;
	localparam logic [31:0] SEED         = 32'h6064_991d;

	logic        clk;
	logic        reset_i;
	logic        imem_req_o;
	logic [31:0] imem_addr_o;
	logic        imem_rvalid_i;
	logic [31:0] imem_rdata_i;
	logic        dmem_req_o;
	logic        dmem_we_o;
	logic [31:0] dmem_addr_o;
	logic [31:0] dmem_wdata_o;
	logic        dmem_rvalid_i;
	logic [31:0] dmem_rdata_i;
	logic [31:0] pc_o;
	logic        finish_o;
	logic        invalid_o;

	logic [31:0] rom [64];
	logic [31:0] dram [64];
	logic [31:0] exp_pc [$];
	logic [31:0] exp_daddr [$];
	logic        exp_dwe [$];
	logic [31:0] exp_dwdata [$];
	int          errors;
	int          i_wait;
	int          d_wait;
	logic [31:0] i_addr;
	logic [31:0] d_addr;
	logic        d_we;
	logic [31:0] d_wdata;
	logic        withhold_data;
	logic        in_reset;

	cpu_top #(
		.RESET_PC       ( RESET_PC      ),
		.TIMEOUT_CYCLES ( 16            )
	) cpu_top_inst (
		.clk            ( clk           ),
		.reset_i        ( reset_i       ),
		.imem_req_o     ( imem_req_o    ),
		.imem_addr_o    ( imem_addr_o   ),
		.imem_rvalid_i  ( imem_rvalid_i ),
		.imem_rdata_i   ( imem_rdata_i  ),
		.dmem_req_o     ( dmem_req_o    ),
		.dmem_we_o      ( dmem_we_o     ),
		.dmem_addr_o    ( dmem_addr_o   ),
		.dmem_wdata_o   ( dmem_wdata_o  ),
		.dmem_rvalid_i  ( dmem_rvalid_i ),
		.dmem_rdata_i   ( dmem_rdata_i  ),
		.pc_o           ( pc_o          ),
		.finish_o       ( finish_o      ),
		.invalid_o      ( invalid_o     )
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			errors++;
			$display("FAILED %s expected %h got %h at %0t", name, exp, act, $time);
		end
	endtask

	task automatic gen_program(input logic [31:0] last_word);
		int          idx;
		int          op;
		int          k;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		logic [11:0] simm;
		logic [12:0] boff;
		logic [20:0] joff;
		logic [2:0]  f3;
		logic [2:0]  alu_f3 [6];
		logic        writes;
		// add, sub, slt, xor, or, and
		alu_f3 = '{3'b000, 3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
		for (int i = 0; i < 64; i++) begin
			rom[i] = rv_isa_pkg::EBREAK_WORD;
		end
		idx = 0;
		while (idx < N_INST - 1) begin
			// x0 as a target checks that writes to it are dropped
			rd     = 5'($urandom_range(0, 7));
			rs1    = 5'($urandom_range(0, 7));
			rs2    = 5'($urandom_range(0, 7));
			imm    = 12'($urandom);
			op     = $urandom_range(0, 5);
			writes = 1'b1;
			// jal needs room for the skipped word and the store behind it
			if (op == 5 && idx > N_INST - 4)
				op = 0;
			case (op)
				0: begin
					k = $urandom_range(0, 5);
					rom[idx] = {(k == 1) ? 7'h20 : 7'h00, rs2, rs1, alu_f3[k], rd,
						rv_isa_pkg::OPC_OP};
				end
				1: begin
					// addi, xori, ori, andi
					k = $urandom_range(0, 3);
					if (k > 0)
						k = k + 2;
					rom[idx] = {imm, rs1, alu_f3[k], rd, rv_isa_pkg::OPC_OP_IMM};
				end
				2: rom[idx] = {20'($urandom), rd, rv_isa_pkg::OPC_LUI};
				3: rom[idx] = {4'b0, imm[5:0], 2'b00, 5'd0, 3'b010, rd, rv_isa_pkg::OPC_LOAD};
				4: begin
					// forward only and never past the last word
					k = $urandom_range(1, (N_INST - 1 - idx < 4) ? N_INST - 1 - idx : 4);
					boff = 13'(k * 4);
					f3 = ($urandom_range(0, 1) == 1) ? rv_isa_pkg::FUNCT3_BNE :
						rv_isa_pkg::FUNCT3_BEQ;
					rom[idx] = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11],
						rv_isa_pkg::OPC_BRANCH};
					writes = 1'b0;
				end
				default: begin
					joff = 21'd8;
					rom[idx] = {joff[20], joff[10:1], joff[11], joff[19:12], rd,
						rv_isa_pkg::OPC_JAL};
					idx++;
					// skipped unless a branch lands here
					rom[idx] = {imm, rs1, 3'b000, rd, rv_isa_pkg::OPC_OP_IMM};
				end
			endcase
			idx++;
			if (writes && idx < N_INST - 1) begin
				simm = {4'b0, 6'($urandom), 2'b00};
				rom[idx] = {simm[11:5], rd, 5'd0, 3'b010, simm[4:0], rv_isa_pkg::OPC_STORE};
				idx++;
			end
		end
		rom[N_INST - 1] = last_word;
	endtask

	task automatic run_model();
		logic [31:0] regs [32];
		logic [31:0] mem [64];
		logic [31:0] pc;
		logic [31:0] inst;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] next;
		logic [31:0] addr;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic [2:0]  f3;
		logic        wr;
		logic        done;
		exp_pc.delete();
		exp_daddr.delete();
		exp_dwe.delete();
		exp_dwdata.delete();
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < 64; i++) begin
			mem[i] = dram[i];
		end
		pc   = RESET_PC;
		done = 1'b0;
		while (!done) begin
			inst  = rom[pc[7:2]];
			exp_pc.push_back(pc);
			f3    = inst[14:12];
			a     = regs[inst[19:15]];
			b     = regs[inst[24:20]];
			imm_i = {{20{inst[31]}}, inst[31:20]};
			imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
			imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
			imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			next  = pc + 32'd4;
			res   = '0;
			wr    = 1'b1;
			case (inst[6:0])
				rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM: begin
					if (inst[6:0] == rv_isa_pkg::OPC_OP_IMM)
						b = imm_i;
					case (f3)
						3'b000: res = (inst[6:0] == rv_isa_pkg::OPC_OP && inst[30]) ? a - b : a + b;
						3'b010: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						3'b100: res = a ^ b;
						3'b110: res = a | b;
						default: res = a & b;
					endcase
				end
				rv_isa_pkg::OPC_LUI: res = {inst[31:12], 12'b0};
				rv_isa_pkg::OPC_LOAD: begin
					addr = a + imm_i;
					exp_daddr.push_back(addr);
					exp_dwe.push_back(1'b0);
					exp_dwdata.push_back(b);
					res = mem[addr[7:2]];
				end
				rv_isa_pkg::OPC_STORE: begin
					addr = a + imm_s;
					exp_daddr.push_back(addr);
					exp_dwe.push_back(1'b1);
					exp_dwdata.push_back(b);
					mem[addr[7:2]] = b;
					wr = 1'b0;
				end
				rv_isa_pkg::OPC_BRANCH: begin
					if ((a == b) != (f3 == rv_isa_pkg::FUNCT3_BNE))
						next = pc + imm_b;
					wr = 1'b0;
				end
				rv_isa_pkg::OPC_JAL: begin
					res  = pc + 32'd4;
					next = pc + imm_j;
				end
				// ebreak or an illegal word ends the fetch sequence
				default: begin
					wr   = 1'b0;
					done = 1'b1;
				end
			endcase
			if (wr && inst[11:7] != 5'd0)
				regs[inst[11:7]] = res;
			pc = next;
		end
	endtask

	task automatic load_program(input logic [31:0] last_word);
		for (int i = 0; i < 64; i++) begin
			// fill depends on every address bit
			dram[i] = (32'(i) * 32'h9E37_79B9) ^ 32'hC3A5_0F1E;
		end
		gen_program(last_word);
		run_model();
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#1;
		reset_i = 1'b1;
		repeat (3) @(posedge clk);
		#1;
		reset_i = 1'b0;
	endtask

	task automatic wait_for_halt();
		@(posedge clk);
		#1;
		while (!(finish_o || invalid_o)) begin
			@(posedge clk);
			#1;
		end
		// any request in this quiet window is flagged by the memory model
		repeat (8) @(posedge clk);
	endtask

	// memory model, answers each request after 1 to MAX_LAT cycles
	always @(posedge clk) begin
		logic        exp_we;
		logic [31:0] exp_wd;
		logic [31:0] exp_fetch;
		in_reset = reset_i;
		#1;
		imem_rvalid_i = 1'b0;
		dmem_rvalid_i = 1'b0;
		if (in_reset) begin
			i_wait = 0;
			d_wait = 0;
		end else begin
			if (i_wait > 0) begin
				i_wait--;
				if (i_wait == 0) begin
					imem_rvalid_i = 1'b1;
					imem_rdata_i  = rom[i_addr[7:2]];
				end
			end
			if (d_wait > 0) begin
				d_wait--;
				if (d_wait == 0) begin
					dmem_rvalid_i = 1'b1;
					if (d_we)
						dram[d_addr[7:2]] = d_wdata;
					else
						dmem_rdata_i = dram[d_addr[7:2]];
				end
			end
			if (imem_req_o) begin
				if (exp_pc.size() == 0) begin
					errors++;
					$display("unexpected instruction fetch at address %h after the program ended",
						imem_addr_o);
				end else begin
					exp_fetch = exp_pc.pop_front();
					check_value("imem_addr_o", exp_fetch, imem_addr_o);
					check_value("pc_o", exp_fetch, pc_o);
				end
				i_addr = imem_addr_o;
				i_wait = $urandom_range(1, MAX_LAT);
			end
			if (dmem_req_o) begin
				if (exp_daddr.size() == 0) begin
					errors++;
					$display("unexpected data request at address %h", dmem_addr_o);
				end else begin
					exp_we = exp_dwe.pop_front();
					exp_wd = exp_dwdata.pop_front();
					check_value("dmem_addr_o", exp_daddr.pop_front(), dmem_addr_o);
					check_value("dmem_we_o", 32'(exp_we), 32'(dmem_we_o));
					if (exp_we)
						check_value("dmem_wdata_o", exp_wd, dmem_wdata_o);
				end
				d_addr  = dmem_addr_o;
				d_we    = dmem_we_o;
				d_wdata = dmem_wdata_o;
				if (withhold_data) begin
					// this response never comes
					withhold_data = 1'b0;
					d_wait = 0;
				end else begin
					d_wait = $urandom_range(1, MAX_LAT);
				end
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests completed, errors: %0d", errors);
		$display("Something failed");
		$finish;
	end

	initial begin
		reset_i       = 1'b1;
		imem_rvalid_i = 1'b0;
		imem_rdata_i  = '0;
		dmem_rvalid_i = 1'b0;
		dmem_rdata_i  = '0;
		errors        = 0;
		i_wait        = 0;
		d_wait        = 0;
		withhold_data = 1'b0;
		void'($urandom(SEED));

		// random program ending in ebreak
		load_program(rv_isa_pkg::EBREAK_WORD);
		apply_reset();
		wait_for_halt();
		check_value("finish_o", 32'd1, 32'(finish_o));
		check_value("invalid_o", 32'd0, 32'(invalid_o));
		if (exp_pc.size() != 0 || exp_daddr.size() != 0) begin
			errors++;
			$display("core stopped with %0d fetches and %0d data accesses still expected",
				exp_pc.size(), exp_daddr.size());
		end

		// same shape, last word illegal
		load_program(ILLEGAL_WORD);
		apply_reset();
		wait_for_halt();
		check_value("invalid_o", 32'd1, 32'(invalid_o));
		check_value("finish_o", 32'd0, 32'(finish_o));
		if (exp_pc.size() != 0 || exp_daddr.size() != 0) begin
			errors++;
			$display("illegal program stopped with %0d fetches still expected", exp_pc.size());
		end

		// first data response is dropped
		load_program(rv_isa_pkg::EBREAK_WORD);
		if (exp_daddr.size() == 0) begin
			errors++;
			$display("timeout program has no data access to withhold");
		end
		withhold_data = 1'b1;
		apply_reset();
		wait_for_halt();
		check_value("invalid_o", 32'd1, 32'(invalid_o));
		check_value("finish_o", 32'd0, 32'(finish_o));

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

/* verilog/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top #(
	parameter logic [core_pkg::DATA_LEN-1:0] RESET_PC = core_pkg::DEFAULT_RESET_PC,
	parameter int TIMEOUT_CYCLES = 16
) (
	input  logic                          clk,
	input  logic                          reset_i,
	output logic                          imem_req_o,
	output logic [core_pkg::DATA_LEN-1:0] imem_addr_o,
	input  logic                          imem_rvalid_i,
	input  logic [core_pkg::DATA_LEN-1:0] imem_rdata_i,
	output logic                          dmem_req_o,
	output logic                          dmem_we_o,
	output logic [core_pkg::DATA_LEN-1:0] dmem_addr_o,
	output logic [core_pkg::DATA_LEN-1:0] dmem_wdata_o,
	input  logic                          dmem_rvalid_i,
	input  logic [core_pkg::DATA_LEN-1:0] dmem_rdata_i,
	output logic [core_pkg::DATA_LEN-1:0] pc_o,
	output logic                          finish_o,
	output logic                          invalid_o
);
	logic [core_pkg::DATA_LEN-1:0] inst;
	core_pkg::state_e              state;
	logic [4:0]                    rs1_addr;
	logic [4:0]                    rs2_addr;
	logic [4:0]                    rd_addr;
	logic [core_pkg::DATA_LEN-1:0] imm;
	rv_isa_pkg::alu_op_e           alu_op;
	logic                          use_imm;
	logic                          is_load;
	logic                          is_store;
	logic                          is_branch;
	logic                          branch_ne;
	logic                          is_jal;
	logic                          is_ebreak;
	logic                          illegal;
	logic                          rf_we_req;
	logic [core_pkg::DATA_LEN-1:0] rs1_data;
	logic [core_pkg::DATA_LEN-1:0] rs2_data;
	logic                          rf_we;
	logic [core_pkg::DATA_LEN-1:0] rf_wdata;
	logic [core_pkg::DATA_LEN-1:0] alu_result;
	logic [core_pkg::DATA_LEN-1:0] next_pc;
	logic                          timeout;

	core_ctrl #(
		.RESET_PC      ( RESET_PC      )
	) u_core_ctrl (
		.clk           ( clk           ),
		.reset_i       ( reset_i       ),
		.imem_rvalid_i ( imem_rvalid_i ),
		.imem_rdata_i  ( imem_rdata_i  ),
		.dmem_rvalid_i ( dmem_rvalid_i ),
		.dmem_rdata_i  ( dmem_rdata_i  ),
		.is_load_i     ( is_load       ),
		.is_store_i    ( is_store      ),
		.is_ebreak_i   ( is_ebreak     ),
		.illegal_i     ( illegal       ),
		.rf_we_req_i   ( rf_we_req     ),
		.next_pc_i     ( next_pc       ),
		.alu_result_i  ( alu_result    ),
		.rs2_data_i    ( rs2_data      ),
		.timeout_i     ( timeout       ),
		.imem_req_o    ( imem_req_o    ),
		.imem_addr_o   ( imem_addr_o   ),
		.dmem_req_o    ( dmem_req_o    ),
		.dmem_we_o     ( dmem_we_o     ),
		.dmem_addr_o   ( dmem_addr_o   ),
		.dmem_wdata_o  ( dmem_wdata_o  ),
		.inst_o        ( inst          ),
		.pc_o          ( pc_o          ),
		.state_o       ( state         ),
		.rf_we_o       ( rf_we         ),
		.rf_wdata_o    ( rf_wdata      ),
		.finish_o      ( finish_o      ),
		.invalid_o     ( invalid_o     )
	);

	// one timer serves both buses, only one request is ever open
	bus_wait_timer #(
		.TIMEOUT_CYCLES ( TIMEOUT_CYCLES                )
	) u_bus_wait_timer (
		.clk            ( clk                           ),
		.reset_i        ( reset_i                       ),
		.state_i        ( state                         ),
		.req_i          ( imem_req_o | dmem_req_o       ),
		.rvalid_i       ( imem_rvalid_i | dmem_rvalid_i ),
		.timeout_o      ( timeout                       )
	);

	decoder u_decoder (
		.inst_i      ( inst      ),
		.rs1_addr_o  ( rs1_addr  ),
		.rs2_addr_o  ( rs2_addr  ),
		.rd_addr_o   ( rd_addr   ),
		.imm_o       ( imm       ),
		.alu_op_o    ( alu_op    ),
		.use_imm_o   ( use_imm   ),
		.is_load_o   ( is_load   ),
		.is_store_o  ( is_store  ),
		.is_branch_o ( is_branch ),
		.branch_ne_o ( branch_ne ),
		.is_jal_o    ( is_jal    ),
		.is_ebreak_o ( is_ebreak ),
		.illegal_o   ( illegal   ),
		.rf_we_req_o ( rf_we_req )
	);

	register_file u_register_file (
		.clk        ( clk      ),
		.reset_i    ( reset_i  ),
		.rs1_addr_i ( rs1_addr ),
		.rs2_addr_i ( rs2_addr ),
		.rs1_data_o ( rs1_data ),
		.rs2_data_o ( rs2_data ),
		.we_i       ( rf_we    ),
		.rd_addr_i  ( rd_addr  ),
		.wdata_i    ( rf_wdata )
	);

	exec_unit u_exec_unit (
		.pc_i         ( pc_o       ),
		.rs1_data_i   ( rs1_data   ),
		.rs2_data_i   ( rs2_data   ),
		.imm_i        ( imm        ),
		.alu_op_i     ( alu_op     ),
		.use_imm_i    ( use_imm    ),
		.is_branch_i  ( is_branch  ),
		.branch_ne_i  ( branch_ne  ),
		.is_jal_i     ( is_jal     ),
		.alu_result_o ( alu_result ),
		.next_pc_o    ( next_pc    )
	);

endmodule

/* verilog/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
	input  logic [core_pkg::DATA_LEN-1:0] pc_i,
	input  logic [core_pkg::DATA_LEN-1:0] rs1_data_i,
	input  logic [core_pkg::DATA_LEN-1:0] rs2_data_i,
	input  logic [core_pkg::DATA_LEN-1:0] imm_i,
	input  rv_isa_pkg::alu_op_e           alu_op_i,
	input  logic                          use_imm_i,
	input  logic                          is_branch_i,
	input  logic                          branch_ne_i,
	input  logic                          is_jal_i,
	output logic [core_pkg::DATA_LEN-1:0] alu_result_o,
	output logic [core_pkg::DATA_LEN-1:0] next_pc_o
);
	logic [core_pkg::DATA_LEN-1:0] operand_b;
	logic [core_pkg::DATA_LEN-1:0] alu_raw;
	logic [core_pkg::DATA_LEN-1:0] pc_plus4;
	logic                          taken;

	assign operand_b = use_imm_i ? imm_i : rs2_data_i;

	// loads and stores come through here as rs1 + imm
	always_comb begin
		case (alu_op_i)
			rv_isa_pkg::ALU_ADD:    alu_raw = rs1_data_i + operand_b;
			rv_isa_pkg::ALU_SUB:    alu_raw = rs1_data_i - operand_b;
			rv_isa_pkg::ALU_AND:    alu_raw = rs1_data_i & operand_b;
			rv_isa_pkg::ALU_OR:     alu_raw = rs1_data_i | operand_b;
			rv_isa_pkg::ALU_XOR:    alu_raw = rs1_data_i ^ operand_b;
			rv_isa_pkg::ALU_SLT: begin
				alu_raw = {{(core_pkg::DATA_LEN-1){1'b0}},
					$signed(rs1_data_i) < $signed(operand_b)};
			end
			rv_isa_pkg::ALU_PASS_B: alu_raw = operand_b;
			default:                alu_raw = '0;
		endcase
	end

	assign pc_plus4 = pc_i + core_pkg::DATA_LEN'(4);

	// branch compare reuses the subtract result
	assign taken = is_branch_i && ((alu_raw == '0) != branch_ne_i);

	assign next_pc_o    = (is_jal_i || taken) ? pc_i + imm_i : pc_plus4;
	// jal links the return address
	assign alu_result_o = is_jal_i ? pc_plus4 : alu_raw;

endmodule

/* verilog/register_file.sv */
`timescale 1ns/1ps

module register_file (
	input  logic                          clk,
	input  logic                          reset_i,
	input  logic [4:0]                    rs1_addr_i,
	input  logic [4:0]                    rs2_addr_i,
	output logic [core_pkg::DATA_LEN-1:0] rs1_data_o,
	output logic [core_pkg::DATA_LEN-1:0] rs2_data_o,
	input  logic                          we_i,
	input  logic [4:0]                    rd_addr_i,
	input  logic [core_pkg::DATA_LEN-1:0] wdata_i
);
	logic [core_pkg::DATA_LEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && rd_addr_i != 5'd0) begin
			regs[rd_addr_i] <= wdata_i;
		end
	end

	// x0 is never written, so it reads zero after reset
	assign rs1_data_o = regs[rs1_addr_i];
	assign rs2_data_o = regs[rs2_addr_i];

	x0_reads_zero: assert property (@(posedge clk) disable iff (reset_i)
		((rs1_addr_i != 5'd0) || (rs1_data_o == '0)) &&
		((rs2_addr_i != 5'd0) || (rs2_data_o == '0)));

endmodule

/* verilog/decoder.sv */
`timescale 1ns/1ps

module decoder (
	input  logic [core_pkg::DATA_LEN-1:0] inst_i,
	output logic [4:0]                    rs1_addr_o,
	output logic [4:0]                    rs2_addr_o,
	output logic [4:0]                    rd_addr_o,
	output logic [core_pkg::DATA_LEN-1:0] imm_o,
	output rv_isa_pkg::alu_op_e           alu_op_o,
	output logic                          use_imm_o,
	output logic                          is_load_o,
	output logic                          is_store_o,
	output logic                          is_branch_o,
	output logic                          branch_ne_o,
	output logic                          is_jal_o,
	output logic                          is_ebreak_o,
	output logic                          illegal_o,
	output logic                          rf_we_req_o
);
	logic [2:0]                    funct3;
	logic [6:0]                    funct7;
	logic [core_pkg::DATA_LEN-1:0] imm_i_t;
	logic [core_pkg::DATA_LEN-1:0] imm_s_t;
	logic [core_pkg::DATA_LEN-1:0] imm_b_t;
	logic [core_pkg::DATA_LEN-1:0] imm_u_t;
	logic [core_pkg::DATA_LEN-1:0] imm_j_t;

	assign rs1_addr_o = inst_i[19:15];
	assign rs2_addr_o = inst_i[24:20];
	assign rd_addr_o  = inst_i[11:7];
	assign funct3     = inst_i[14:12];
	assign funct7     = inst_i[31:25];

	assign imm_i_t = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s_t = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b_t = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
		inst_i[11:8], 1'b0};
	assign imm_u_t = {inst_i[31:12], 12'b0};
	assign imm_j_t = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
		inst_i[30:21], 1'b0};

	always_comb begin
		imm_o       = imm_i_t;
		alu_op_o    = rv_isa_pkg::ALU_ADD;
		use_imm_o   = 1'b0;
		is_load_o   = 1'b0;
		is_store_o  = 1'b0;
		is_branch_o = 1'b0;
		branch_ne_o = 1'b0;
		is_jal_o    = 1'b0;
		is_ebreak_o = 1'b0;
		illegal_o   = 1'b0;
		rf_we_req_o = 1'b0;
		case (rv_isa_pkg::opcode_e'(inst_i[6:0]))
			rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_IMM: begin
				rf_we_req_o = 1'b1;
				use_imm_o   = (inst_i[6:0] == rv_isa_pkg::OPC_OP_IMM);
				case (funct3)
					rv_isa_pkg::FUNCT3_ADD_SUB: begin
						if (!use_imm_o && funct7 == rv_isa_pkg::FUNCT7_ALT)
							alu_op_o = rv_isa_pkg::ALU_SUB;
					end
					rv_isa_pkg::FUNCT3_XOR: alu_op_o = rv_isa_pkg::ALU_XOR;
					rv_isa_pkg::FUNCT3_OR:  alu_op_o = rv_isa_pkg::ALU_OR;
					rv_isa_pkg::FUNCT3_AND: alu_op_o = rv_isa_pkg::ALU_AND;
					// slti is outside the subset
					rv_isa_pkg::FUNCT3_SLT: begin
						alu_op_o  = rv_isa_pkg::ALU_SLT;
						illegal_o = use_imm_o;
					end
					default: illegal_o = 1'b1;
				endcase
				// only add may carry the alt funct7
				if (!use_imm_o && funct7 != rv_isa_pkg::FUNCT7_BASE &&
					!(funct7 == rv_isa_pkg::FUNCT7_ALT &&
					  funct3 == rv_isa_pkg::FUNCT3_ADD_SUB))
					illegal_o = 1'b1;
			end
			rv_isa_pkg::OPC_LUI: begin
				imm_o       = imm_u_t;
				alu_op_o    = rv_isa_pkg::ALU_PASS_B;
				use_imm_o   = 1'b1;
				rf_we_req_o = 1'b1;
			end
			rv_isa_pkg::OPC_LOAD: begin
				use_imm_o   = 1'b1;
				is_load_o   = 1'b1;
				rf_we_req_o = 1'b1;
				illegal_o   = (funct3 != rv_isa_pkg::FUNCT3_LW);
			end
			rv_isa_pkg::OPC_STORE: begin
				imm_o      = imm_s_t;
				use_imm_o  = 1'b1;
				is_store_o = 1'b1;
				illegal_o  = (funct3 != rv_isa_pkg::FUNCT3_SW);
			end
			rv_isa_pkg::OPC_BRANCH: begin
				// compare through the subtractor
				imm_o       = imm_b_t;
				alu_op_o    = rv_isa_pkg::ALU_SUB;
				is_branch_o = 1'b1;
				branch_ne_o = (funct3 == rv_isa_pkg::FUNCT3_BNE);
				illegal_o   = (funct3 != rv_isa_pkg::FUNCT3_BEQ) &&
					(funct3 != rv_isa_pkg::FUNCT3_BNE);
			end
			rv_isa_pkg::OPC_JAL: begin
				imm_o       = imm_j_t;
				is_jal_o    = 1'b1;
				rf_we_req_o = 1'b1;
			end
			rv_isa_pkg::OPC_SYSTEM: begin
				is_ebreak_o = (inst_i == rv_isa_pkg::EBREAK_WORD);
				illegal_o   = !is_ebreak_o;
			end
			default: illegal_o = 1'b1;
		endcase
	end

endmodule

/* verilog/bus_wait_timer.sv */
`timescale 1ns/1ps

module bus_wait_timer #(
	parameter int TIMEOUT_CYCLES = 16
) (
	input  logic             clk,
	input  logic             reset_i,
	input  core_pkg::state_e state_i,
	input  logic             req_i,
	input  logic             rvalid_i,
	output logic             timeout_o
);
	localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

	logic [CNT_W-1:0] count;
	logic             waiting;

	assign waiting = (state_i == core_pkg::WAIT_I) || (state_i == core_pkg::WAIT_D);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			count     <= '0;
			timeout_o <= 1'b0;
		end else begin
			// count saturates, so the pulse fires once per request
			timeout_o <= waiting && !rvalid_i && (count == CNT_W'(TIMEOUT_CYCLES - 1));
			if (req_i || rvalid_i)
				count <= '0;
			else if (waiting && count != CNT_W'(TIMEOUT_CYCLES))
				count <= count + 1'b1;
		end
	end

	// memory answers only while the core is waiting for it
	rvalid_in_wait: assert property (@(posedge clk) disable iff (reset_i)
		rvalid_i |-> waiting);

endmodule

/* verilog/core_ctrl.sv */
`timescale 1ns/1ps

module core_ctrl #(
	parameter logic [core_pkg::DATA_LEN-1:0] RESET_PC = core_pkg::DEFAULT_RESET_PC
) (
	input  logic                            clk,
	input  logic                            reset_i,
	input  logic                            imem_rvalid_i,
	input  logic [core_pkg::DATA_LEN-1:0]   imem_rdata_i,
	input  logic                            dmem_rvalid_i,
	input  logic [core_pkg::DATA_LEN-1:0]   dmem_rdata_i,
	input  logic                            is_load_i,
	input  logic                            is_store_i,
	input  logic                            is_ebreak_i,
	input  logic                            illegal_i,
	input  logic                            rf_we_req_i,
	input  logic [core_pkg::DATA_LEN-1:0]   next_pc_i,
	input  logic [core_pkg::DATA_LEN-1:0]   alu_result_i,
	input  logic [core_pkg::DATA_LEN-1:0]   rs2_data_i,
	input  logic                            timeout_i,
	output logic                            imem_req_o,
	output logic [core_pkg::DATA_LEN-1:0]   imem_addr_o,
	output logic                            dmem_req_o,
	output logic                            dmem_we_o,
	output logic [core_pkg::DATA_LEN-1:0]   dmem_addr_o,
	output logic [core_pkg::DATA_LEN-1:0]   dmem_wdata_o,
	output logic [core_pkg::DATA_LEN-1:0]   inst_o,
	output logic [core_pkg::DATA_LEN-1:0]   pc_o,
	output core_pkg::state_e                state_o,
	output logic                            rf_we_o,
	output logic [core_pkg::DATA_LEN-1:0]   rf_wdata_o,
	output logic                            finish_o,
	output logic                            invalid_o
);
	core_pkg::state_e              state;
	core_pkg::state_e              state_next;
	logic [core_pkg::DATA_LEN-1:0] pc;
	logic [core_pkg::DATA_LEN-1:0] ir;
	logic [core_pkg::DATA_LEN-1:0] load_data;
	logic                          ir_load;
	logic                          wait_timeout;
	logic                          req_open;

	// instruction word is captured on the edge into DECODE
	assign ir_load = (state == core_pkg::WAIT_I) && imem_rvalid_i;

	// a response in the same cycle wins over the timeout
	assign wait_timeout = timeout_i &&
		((state == core_pkg::WAIT_I && !imem_rvalid_i) ||
		 (state == core_pkg::WAIT_D && !dmem_rvalid_i));

	always_comb begin
		state_next = state;
		case (state)
			core_pkg::IDLE:   state_next = core_pkg::FETCH;
			core_pkg::FETCH:  state_next = core_pkg::WAIT_I;
			core_pkg::WAIT_I: begin
				if (imem_rvalid_i)
					state_next = core_pkg::DECODE;
				else if (wait_timeout)
					state_next = core_pkg::HALT;
			end
			core_pkg::DECODE: begin
				if (is_ebreak_i || illegal_i)
					state_next = core_pkg::HALT;
				else
					state_next = core_pkg::EXEC;
			end
			core_pkg::EXEC: begin
				if (is_load_i || is_store_i)
					state_next = core_pkg::MEM;
				else
					state_next = core_pkg::WB;
			end
			core_pkg::MEM:    state_next = core_pkg::WAIT_D;
			core_pkg::WAIT_D: begin
				if (dmem_rvalid_i)
					state_next = core_pkg::WB;
				else if (wait_timeout)
					state_next = core_pkg::HALT;
			end
			core_pkg::WB:     state_next = core_pkg::FETCH;
			default:          state_next = core_pkg::HALT;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state     <= core_pkg::IDLE;
			pc        <= RESET_PC;
			finish_o  <= 1'b0;
			invalid_o <= 1'b0;
		end else begin
			state <= state_next;
			if (state == core_pkg::WB)
				pc <= next_pc_i;
			if (state == core_pkg::DECODE && is_ebreak_i)
				finish_o <= 1'b1;
			// halt causes stay latched until the next reset
			if ((state == core_pkg::DECODE && illegal_i) || wait_timeout)
				invalid_o <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (ir_load)
			ir <= imem_rdata_i;
		if (state == core_pkg::WAIT_D && dmem_rvalid_i)
			load_data <= dmem_rdata_i;
	end

	// set by a request, cleared by its response
	always_ff @(posedge clk) begin
		if (reset_i)
			req_open <= 1'b0;
		else if (imem_req_o || dmem_req_o)
			req_open <= 1'b1;
		else if (imem_rvalid_i || dmem_rvalid_i)
			req_open <= 1'b0;
	end

	assign imem_req_o   = (state == core_pkg::FETCH);
	assign imem_addr_o  = pc;
	assign dmem_req_o   = (state == core_pkg::MEM);
	assign dmem_we_o    = (state == core_pkg::MEM) && is_store_i;
	assign dmem_addr_o  = alu_result_i;
	assign dmem_wdata_o = rs2_data_i;
	assign inst_o       = ir;
	assign pc_o         = pc;
	assign state_o      = state;
	assign rf_we_o      = (state == core_pkg::WB) && rf_we_req_i;
	assign rf_wdata_o   = is_load_i ? load_data : alu_result_i;

	// a strobe only goes out once the previous request was answered
	req_after_rsp: assert property (@(posedge clk) disable iff (reset_i)
		(imem_req_o || dmem_req_o) |-> !req_open);

endmodule

/* verilog/core_pkg.sv */
package core_pkg;

	localparam int DATA_LEN = 32;

	// boot address used when the top level does not override it
	localparam logic [DATA_LEN-1:0] DEFAULT_RESET_PC = '0;

	// one instruction in flight, walked through these states
	typedef enum logic [3:0] {
		IDLE,
		FETCH,
		WAIT_I,
		DECODE,
		EXEC,
		MEM,
		WAIT_D,
		WB,
		HALT
	} state_e;

endpackage

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

	// major opcodes of the supported subset
	typedef enum logic [6:0] {
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_AND    = 4'd2,
		ALU_OR     = 4'd3,
		ALU_XOR    = 4'd4,
		ALU_SLT    = 4'd5,
		// lui passes the immediate straight through
		ALU_PASS_B = 4'd6
	} alu_op_e;

	// funct3 of register and immediate alu ops
	localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
	localparam logic [2:0] FUNCT3_SLT     = 3'b010;
	localparam logic [2:0] FUNCT3_XOR     = 3'b100;
	localparam logic [2:0] FUNCT3_OR      = 3'b110;
	localparam logic [2:0] FUNCT3_AND     = 3'b111;

	// word access only
	localparam logic [2:0] FUNCT3_LW      = 3'b010;
	localparam logic [2:0] FUNCT3_SW      = 3'b010;

	localparam logic [2:0] FUNCT3_BEQ     = 3'b000;
	localparam logic [2:0] FUNCT3_BNE     = 3'b001;

	// funct7 of register ops, alt selects sub
	localparam logic [6:0] FUNCT7_BASE    = 7'b0000000;
	localparam logic [6:0] FUNCT7_ALT     = 7'b0100000;

	localparam logic [31:0] EBREAK_WORD   = 32'h0010_0073;

endpackage
